/* rtl/usb_pid_pkg.sv */
package usb_pid_pkg;

	// Decoded host PID level from the RX front end
	typedef enum logic [2:0] {
		RX_IDLE = 3'd0,	// Nothing on the bus
		RX_IN   = 3'd1,	// IN token
		RX_OUT  = 3'd2,	// OUT token
		RX_DATA = 3'd3,	// Data packet in progress
		RX_GOOD = 3'd4,	// Data packet ended clean
		RX_BAD  = 3'd5,	// Data packet ended corrupt
		RX_ACK  = 3'd6,	// Host handshake ACK
		RX_NAK  = 3'd7	// Host handshake NAK
	} rx_pid_t;

	// Packet request to the TX side
	typedef enum logic [1:0] {
		TX_NONE = 2'd0,	// Idle
		TX_DATA = 2'd1,
		TX_ACK  = 2'd2,
		TX_NAK  = 2'd3
	} tx_pid_t;

	// On-wire PID bytes, check nibble included
	localparam logic [7:0] PID_BYTE_ACK   = 8'hD2;
	localparam logic [7:0] PID_BYTE_NAK   = 8'h5A;
	localparam logic [7:0] PID_BYTE_DATA0 = 8'hC3;

endpackage

/* rtl/usb_buf_pkg.sv */
package usb_buf_pkg;

	// Endpoint buffer capacity in bytes
	localparam int BUF_DEPTH = 64;

	// One payload byte
	typedef logic [7:0] byte_t;

	// Fill level, 0 up to BUF_DEPTH inclusive
	typedef logic [6:0] occ_t;

	// Index into the buffer storage
	typedef logic [5:0] ptr_t;

endpackage

/* rtl/buf_if.sv */
`timescale 1ns/1ps

// Buffer side channel shared by the controller and the TX sender
interface buf_if
	import usb_buf_pkg::*;
();
	occ_t  occupancy;	// Bytes currently held
	logic  clear;	// Flush request, one cycle
	logic  rd_en;	// Pop the head byte
	byte_t rd_data;	// Head byte, first word fall through

	modport buffer (
		output occupancy,
		output rd_data,
		input  clear,
		input  rd_en
	);

	modport ctrl (
		input  occupancy,
		output clear
	);

	modport sender (
		input  occupancy,
		input  rd_data,
		output rd_en
	);
endinterface

/* rtl/protocol_controller.sv */
`timescale 1ns/1ps

module protocol_controller
	import usb_pid_pkg::*, usb_buf_pkg::*;
(
	input  logic    clk,
	input  logic    n_rst,
	input  rx_pid_t rx_packet,	// Decoded host PID
	input  logic    tx_done,	// Sender finished a packet
	input  logic    buffer_reserved,	// AHB side wants to load the buffer
	input  occ_t    tx_packet_data_size,	// Bytes the AHB side will load
	buf_if.ctrl     bus,
	output logic    rx_data_ready,
	output logic    rx_transfer_active,
	output logic    rx_error,
	output logic    tx_transfer_active,
	output logic    tx_error,
	output logic    d_mode,	// High while the endpoint drives the bus
	output tx_pid_t tx_packet
);
	typedef enum logic [4:0] {
		IDLE,
		// Host to endpoint
		RX_ACTIVE, HE_DATA, HE_GOOD, SEND_ACK, HE_PACKET_DONE_WAIT, DATA_BUFFER_WAIT,
		// Old data still waiting for the AHB side
		HE_ERROR_START, HE_TX_ERROR, HE_PACKET_ERROR_WAIT,
		// Endpoint to host
		AHB_STORE, TX_ACTIVE, EH_DATA, EH_PACKET_DONE_WAIT, EH_DONE,
		TX_ERROR_SET,	// Host answered NAK
		HE_BAD,	// Corrupt host data
		// NAK back to the host
		EH_ERROR_START, EH_TX_ERROR, EH_PACKET_ERROR_WAIT
	} ctrl_state_t;

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic    rx_data_ready_next;
	logic    rx_transfer_active_next;
	logic    rx_error_next;
	logic    tx_transfer_active_next;
	logic    tx_error_next;
	logic    clear_next;
	logic    d_mode_next;
	tx_pid_t tx_packet_next;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (rx_packet == RX_OUT)
					next_state = RX_ACTIVE;
				else if (rx_packet == RX_IN)	// Nothing loaded yet
					next_state = EH_ERROR_START;
				else if (buffer_reserved)
					next_state = AHB_STORE;
			end
			RX_ACTIVE: next_state = HE_DATA;
			HE_DATA: begin
				if (rx_packet == RX_GOOD)
					next_state = HE_GOOD;
				else if (rx_packet == RX_BAD)
					next_state = HE_BAD;
			end
			HE_GOOD: next_state = SEND_ACK;
			SEND_ACK: next_state = HE_PACKET_DONE_WAIT;
			HE_PACKET_DONE_WAIT: begin
				if (tx_done)
					next_state = DATA_BUFFER_WAIT;
			end
			DATA_BUFFER_WAIT: begin
				// Hold off the host until the AHB side drains the data
				if (bus.occupancy == '0)
					next_state = IDLE;
				else if (rx_packet == RX_IN || rx_packet == RX_OUT)
					next_state = HE_ERROR_START;
			end
			HE_ERROR_START: next_state = HE_TX_ERROR;
			HE_TX_ERROR: next_state = HE_PACKET_ERROR_WAIT;
			HE_PACKET_ERROR_WAIT: begin
				if (tx_done)
					next_state = DATA_BUFFER_WAIT;
			end
			AHB_STORE: begin
				if (rx_packet == RX_IN && bus.occupancy == tx_packet_data_size)
					next_state = TX_ACTIVE;
				else if (rx_packet == RX_OUT)	// Wrong direction for a loaded buffer
					next_state = EH_ERROR_START;
			end
			TX_ACTIVE: next_state = EH_DATA;
			EH_DATA: begin
				// Sender may report done in the same cycle the buffer runs dry
				if (bus.occupancy == '0)
					next_state = tx_done ? EH_DONE : EH_PACKET_DONE_WAIT;
			end
			EH_PACKET_DONE_WAIT: begin
				if (tx_done)
					next_state = EH_DONE;
			end
			EH_DONE: begin
				if (rx_packet == RX_ACK)
					next_state = IDLE;
				else if (rx_packet == RX_NAK)
					next_state = TX_ERROR_SET;
			end
			TX_ERROR_SET: next_state = IDLE;
			HE_BAD: next_state = EH_ERROR_START;	// Flush, then NAK
			EH_ERROR_START: next_state = EH_TX_ERROR;
			EH_TX_ERROR: next_state = EH_PACKET_ERROR_WAIT;
			EH_PACKET_ERROR_WAIT: begin
				if (tx_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	// Moore outputs, registered one cycle behind the state
	always_comb begin
		rx_data_ready_next      = rx_data_ready;	// Sticky
		rx_error_next           = rx_error;	// Sticky
		tx_error_next           = tx_error;	// Sticky
		rx_transfer_active_next = 1'b0;
		tx_transfer_active_next = 1'b0;
		clear_next              = 1'b0;
		d_mode_next             = 1'b0;
		tx_packet_next          = TX_NONE;
		case (state)
			RX_ACTIVE: begin
				// New transfer drops the old flags
				rx_data_ready_next      = 1'b0;
				rx_error_next           = 1'b0;
				tx_error_next           = 1'b0;
				rx_transfer_active_next = 1'b1;
			end
			HE_DATA: rx_transfer_active_next = 1'b1;
			HE_GOOD: begin
				rx_data_ready_next      = 1'b1;
				tx_transfer_active_next = 1'b1;
				d_mode_next             = 1'b1;
			end
			SEND_ACK: begin
				tx_transfer_active_next = 1'b1;
				d_mode_next             = 1'b1;
				tx_packet_next          = TX_ACK;	// Single cycle request
			end
			HE_TX_ERROR, EH_TX_ERROR: begin
				tx_transfer_active_next = 1'b1;
				d_mode_next             = 1'b1;
				tx_packet_next          = TX_NAK;
				rx_error_next           = 1'b1;
			end
			HE_PACKET_ERROR_WAIT: begin
				tx_transfer_active_next = 1'b1;
				d_mode_next             = 1'b1;
				rx_error_next           = 1'b1;
			end
			AHB_STORE: begin
				rx_data_ready_next = 1'b0;
				rx_error_next      = 1'b0;
				tx_error_next      = 1'b0;
			end
			TX_ACTIVE: begin
				tx_transfer_active_next = 1'b1;
				d_mode_next             = 1'b1;
				tx_packet_next          = TX_DATA;
			end
			HE_PACKET_DONE_WAIT, HE_ERROR_START, EH_DATA, EH_PACKET_DONE_WAIT,
			EH_ERROR_START, EH_PACKET_ERROR_WAIT: begin
				tx_transfer_active_next = 1'b1;
				d_mode_next             = 1'b1;
			end
			TX_ERROR_SET: tx_error_next = 1'b1;
			HE_BAD: clear_next = 1'b1;	// Drop the corrupt payload
			default: ;	// IDLE, DATA_BUFFER_WAIT, EH_DONE keep defaults
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			rx_data_ready      <= 1'b0;
			rx_transfer_active <= 1'b0;
			rx_error           <= 1'b0;
			tx_transfer_active <= 1'b0;
			tx_error           <= 1'b0;
			bus.clear          <= 1'b0;
			d_mode             <= 1'b0;
			tx_packet          <= TX_NONE;
		end else begin
			rx_data_ready      <= rx_data_ready_next;
			rx_transfer_active <= rx_transfer_active_next;
			rx_error           <= rx_error_next;
			tx_transfer_active <= tx_transfer_active_next;
			tx_error           <= tx_error_next;
			bus.clear          <= clear_next;
			d_mode             <= d_mode_next;
			tx_packet          <= tx_packet_next;
		end
	end

	// Data is only ever requested with the endpoint driving the bus
	a_data_in_d_mode: assert property (@(posedge clk) disable iff (!n_rst)
		(tx_packet == TX_DATA) |-> d_mode);

	// Flush is a pulse, never a level
	a_clear_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		bus.clear |=> !bus.clear);

endmodule

/* rtl/data_buffer.sv */
`timescale 1ns/1ps

module data_buffer
	import usb_buf_pkg::*;
(
	input  logic  clk,
	input  logic  n_rst,
	buf_if.buffer bus,
	input  byte_t rx_byte,	// Host payload
	input  logic  rx_byte_valid,
	input  logic  rx_transfer_active,	// Selects the host as writer
	input  byte_t ahb_wr_data,
	input  logic  ahb_wr_en,
	input  logic  ahb_rd_en,
	output byte_t ahb_rd_data
);
	byte_t mem [BUF_DEPTH];
	ptr_t  wr_ptr;
	ptr_t  rd_ptr;
	occ_t  count;
	logic  wr_req;
	byte_t wr_data;
	logic  do_wr;
	logic  do_rd;

	// Host owns the write port during an OUT data phase
	assign wr_req  = rx_transfer_active ? rx_byte_valid : ahb_wr_en;
	assign wr_data = rx_transfer_active ? rx_byte : ahb_wr_data;

	assign do_wr = wr_req && (count != occ_t'(BUF_DEPTH));	// Full drops the write
	assign do_rd = (bus.rd_en || ahb_rd_en) && (count != '0);	// Empty ignores the pop

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (bus.clear) begin	// Flush wins over everything
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr && !bus.clear)
			mem[wr_ptr] <= wr_data;
	end

	// Head byte always visible on both read sides
	assign bus.rd_data   = mem[rd_ptr];
	assign ahb_rd_data   = mem[rd_ptr];
	assign bus.occupancy = count;

	a_occ_bound: assert property (@(posedge clk) disable iff (!n_rst)
		bus.occupancy <= occ_t'(BUF_DEPTH));

endmodule

/* rtl/tx_packet_sender.sv */
`timescale 1ns/1ps

module tx_packet_sender
	import usb_pid_pkg::*, usb_buf_pkg::*;
(
	input  logic    clk,
	input  logic    n_rst,
	input  tx_pid_t tx_packet,	// One cycle request
	buf_if.sender   bus,
	output byte_t   tx_byte,
	output logic    tx_byte_valid,
	output logic    tx_done
);
	typedef enum logic [1:0] {IDLE, PID, DATA, DONE} snd_state_t;

	snd_state_t state;
	snd_state_t next_state;
	tx_pid_t    pid_q;	// Request being served
	byte_t      pid_byte;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && tx_packet != TX_NONE)
			pid_q <= tx_packet;
	end

	always_comb begin
		case (pid_q)
			TX_DATA: pid_byte = PID_BYTE_DATA0;	// Only DATA0, no toggle
			TX_ACK:  pid_byte = PID_BYTE_ACK;
			default: pid_byte = PID_BYTE_NAK;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (tx_packet != TX_NONE) next_state = PID;
			PID:  next_state = (pid_q == TX_DATA) ? DATA : DONE;
			// Leave once the last byte goes out this cycle
			DATA: if (bus.occupancy <= occ_t'(1)) next_state = DONE;
			DONE: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	assign bus.rd_en     = (state == DATA) && (bus.occupancy != '0);	// One pop per cycle
	assign tx_byte_valid = (state == PID) || bus.rd_en;
	assign tx_byte       = (state == PID) ? pid_byte :
	                       (state == DATA) ? bus.rd_data : '0;
	assign tx_done       = (state == DONE);

	a_done_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		tx_done |=> !tx_done);

endmodule

/* rtl/usb_endpoint_top.sv */
`timescale 1ns/1ps

module usb_endpoint_top
	import usb_pid_pkg::*, usb_buf_pkg::*;
(
	input  logic    clk,
	input  logic    n_rst,
	input  rx_pid_t rx_packet,	// Decoded PID level
	input  byte_t   rx_byte,
	input  logic    rx_byte_valid,
	input  byte_t   ahb_wr_data,
	input  logic    ahb_wr_en,
	input  logic    ahb_rd_en,
	input  logic    buffer_reserved,
	input  occ_t    tx_packet_data_size,
	output byte_t   ahb_rd_data,
	output byte_t   tx_byte,
	output logic    tx_byte_valid,
	output logic    rx_data_ready,
	output logic    rx_transfer_active,
	output logic    rx_error,
	output logic    tx_transfer_active,
	output logic    tx_error,
	output logic    d_mode
);
	tx_pid_t tx_packet;	// Controller to sender request
	logic    tx_done;

	buf_if u_buf_if ();

	protocol_controller u_protocol_controller (
		.clk                 (clk),
		.n_rst               (n_rst),
		.rx_packet           (rx_packet),
		.tx_done             (tx_done),
		.buffer_reserved     (buffer_reserved),
		.tx_packet_data_size (tx_packet_data_size),
		.bus                 (u_buf_if.ctrl),
		.rx_data_ready       (rx_data_ready),
		.rx_transfer_active  (rx_transfer_active),
		.rx_error            (rx_error),
		.tx_transfer_active  (tx_transfer_active),
		.tx_error            (tx_error),
		.d_mode              (d_mode),
		.tx_packet           (tx_packet)
	);

	data_buffer u_data_buffer (
		.clk                (clk),
		.n_rst              (n_rst),
		.bus                (u_buf_if.buffer),
		.rx_byte            (rx_byte),
		.rx_byte_valid      (rx_byte_valid),
		.rx_transfer_active (rx_transfer_active),	// Also a status output
		.ahb_wr_data        (ahb_wr_data),
		.ahb_wr_en          (ahb_wr_en),
		.ahb_rd_en          (ahb_rd_en),
		.ahb_rd_data        (ahb_rd_data)
	);

	tx_packet_sender u_tx_packet_sender (
		.clk           (clk),
		.n_rst         (n_rst),
		.tx_packet     (tx_packet),
		.bus           (u_buf_if.sender),
		.tx_byte       (tx_byte),
		.tx_byte_valid (tx_byte_valid),
		.tx_done       (tx_done)
	);

endmodule

/* dv/tb_usb_endpoint.sv */
`timescale 1ns/1ps

module tb_usb_endpoint
	import usb_pid_pkg::*, usb_buf_pkg::*;
();
	localparam int RESET_CYCLES = 4;
	localparam int WAIT_LIMIT   = 150;	// Longest single wait with a full buffer
	localparam int NUM_SCEN     = 10;

	typedef enum logic [2:0] {
		S_IN_EMPTY,	// IN with nothing loaded gets a NAK
		S_OUT_GOOD,	// Good OUT followed by an AHB drain
		S_OUT_BAD,	// Bad OUT flushes the buffer
		S_IN_DATA,	// AHB load answered by DATA0 and payload
		S_OUT_BUSY	// Second OUT while data still unread
	} scen_kind_t;

	typedef struct packed {
		scen_kind_t kind;
		occ_t       n_bytes;
		rx_pid_t    reply;	// Host handshake for IN_DATA
	} scen_t;

	scen_t scen_tbl [NUM_SCEN] = '{
		'{S_IN_EMPTY, 7'd1,  RX_IDLE},
		'{S_OUT_GOOD, 7'd5,  RX_IDLE},
		'{S_OUT_GOOD, 7'd64, RX_IDLE},	// Fills the buffer exactly
		'{S_OUT_BAD,  7'd7,  RX_IDLE},
		'{S_IN_DATA,  7'd12, RX_ACK},
		'{S_IN_DATA,  7'd40, RX_NAK},
		'{S_OUT_BUSY, 7'd9,  RX_IDLE},
		'{S_IN_DATA,  7'd1,  RX_ACK},
		'{S_OUT_BAD,  7'd30, RX_IDLE},
		'{S_OUT_GOOD, 7'd1,  RX_IDLE}
	};

	logic    clk;
	logic    n_rst;
	rx_pid_t rx_packet;
	byte_t   rx_byte;
	logic    rx_byte_valid;
	byte_t   ahb_wr_data;
	logic    ahb_wr_en;
	logic    ahb_rd_en;
	logic    buffer_reserved;
	occ_t    tx_packet_data_size;
	byte_t   ahb_rd_data;
	byte_t   tx_byte;
	logic    tx_byte_valid;
	logic    rx_data_ready;
	logic    rx_transfer_active;
	logic    rx_error;
	logic    tx_transfer_active;
	logic    tx_error;
	logic    d_mode;

	byte_t model_q [$];	// Expected buffer contents from the head
	byte_t exp_tx [$];	// Expected TX bytes of the current scenario
	byte_t tx_log [$];	// Every TX byte seen by the monitor
	int    tx_base;	// First tx_log entry of the current scenario
	int    n_mismatch;
	int    n_other;
	int    flag_mismatch;	// Counted by the monitor

	usb_endpoint_top u_usb_endpoint_top (
		.clk                 (clk),
		.n_rst               (n_rst),
		.rx_packet           (rx_packet),
		.rx_byte             (rx_byte),
		.rx_byte_valid       (rx_byte_valid),
		.ahb_wr_data         (ahb_wr_data),
		.ahb_wr_en           (ahb_wr_en),
		.ahb_rd_en           (ahb_rd_en),
		.buffer_reserved     (buffer_reserved),
		.tx_packet_data_size (tx_packet_data_size),
		.ahb_rd_data         (ahb_rd_data),
		.tx_byte             (tx_byte),
		.tx_byte_valid       (tx_byte_valid),
		.rx_data_ready       (rx_data_ready),
		.rx_transfer_active  (rx_transfer_active),
		.rx_error            (rx_error),
		.tx_transfer_active  (tx_transfer_active),
		.tx_error            (tx_error),
		.d_mode              (d_mode)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 100 MHz
	end

	// Every TX byte must go out with the endpoint owning the bus
	always @(posedge clk) begin
		if (n_rst && tx_byte_valid) begin
			tx_log.push_back(tx_byte);
			assert (tx_transfer_active && d_mode) else begin
				flag_mismatch++;
				$display("Mismatch at %0t: TX byte %h sent outside an active transfer",
					$time, tx_byte);
			end
		end
	end

	// Budget of byte count plus 40 cycles per scenario
	initial begin
		int budget;
		budget = RESET_CYCLES + 2;
		foreach (scen_tbl[i])
			budget += scen_tbl[i].n_bytes + 40;
		repeat (budget) @(posedge clk);
		$display("Run timed out after %0d cycles, scenarios did not complete", budget);
		$display("Testbench failed");
		$finish;
	end

	task automatic check_bit(input logic got, input logic exp, input string what);
		assert (got === exp) else begin
			n_mismatch++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		assert (got === exp) else begin
			n_mismatch++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Compare TX bytes since the last call with the expected list
	task automatic check_tx(input string what);
		int got_n;
		int k;
		got_n = tx_log.size() - tx_base;
		assert (got_n == exp_tx.size()) else begin
			n_mismatch++;
			$display("Mismatch at %0t: %s sent %0d TX bytes, expected %0d",
				$time, what, got_n, exp_tx.size());
		end
		for (k = 0; k < exp_tx.size() && k < got_n; k++)
			check_byte(tx_log[tx_base + k], exp_tx[k], what);
		tx_base = tx_log.size();
		exp_tx.delete();
	endtask

	// One cycle PID level before returning to idle
	task automatic send_pid(input rx_pid_t pid);
		rx_packet <= pid;
		@(posedge clk);
		rx_packet <= RX_IDLE;
	endtask

	task automatic wait_rx_active();
		int cyc;
		cyc = 0;
		while (!rx_transfer_active && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		assert (cyc < WAIT_LIMIT) else begin
			n_other++;
			$display("rx_transfer_active never rose after an OUT token");
		end
	endtask

	// Rise then fall of tx_transfer_active brackets one packet
	task automatic wait_tx_packet(input string what);
		int cyc;
		cyc = 0;
		while (!tx_transfer_active && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		while (tx_transfer_active && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		assert (cyc < WAIT_LIMIT) else begin
			n_other++;
			$display("No complete TX packet for %s within %0d cycles", what, WAIT_LIMIT);
		end
	endtask

	// Back to back pops with the head sampled before each pop lands
	task automatic ahb_drain(input int n);
		int k;
		ahb_rd_en <= 1'b1;
		for (k = 0; k < n; k++) begin
			@(posedge clk);
			check_byte(ahb_rd_data, model_q.pop_front(), "AHB read data");
		end
		ahb_rd_en <= 1'b0;
	endtask

	// A pop on an empty buffer must leave the next write at the head
	task automatic check_empty_pop();
		byte_t probe;
		probe = byte_t'($urandom());
		ahb_rd_en <= 1'b1;	// Nothing to pop
		@(posedge clk);
		ahb_rd_en   <= 1'b0;
		ahb_wr_data <= probe;
		ahb_wr_en   <= 1'b1;
		@(posedge clk);
		ahb_wr_en <= 1'b0;
		@(posedge clk);
		check_byte(ahb_rd_data, probe, "AHB head after pop on empty buffer");
		ahb_rd_en <= 1'b1;	// Remove the probe again
		@(posedge clk);
		ahb_rd_en <= 1'b0;
	endtask

	// OUT token and n payload bytes ending in GOOD or BAD
	task automatic host_out(input int n, input rx_pid_t ending);
		byte_t b;
		int    k;
		rx_packet <= RX_OUT;
		@(posedge clk);
		rx_packet <= RX_DATA;
		wait_rx_active();
		for (k = 0; k < n; k++) begin
			b = byte_t'($urandom());
			rx_byte       <= b;
			rx_byte_valid <= 1'b1;
			if (model_q.size() < BUF_DEPTH)
				model_q.push_back(b);	// Full buffer drops the write
			@(posedge clk);
		end
		rx_byte_valid <= 1'b0;
		rx_packet     <= ending;
		@(posedge clk);
		rx_packet <= RX_IDLE;
	endtask

	task automatic run_in_empty();
		send_pid(RX_IN);
		exp_tx.push_back(PID_BYTE_NAK);
		wait_tx_packet("IN on empty buffer");
		check_tx("NAK to IN on empty buffer");
		check_bit(rx_error, 1'b1, "rx_error after NAK to IN");
	endtask

	task automatic run_out_good(input int n);
		host_out(n, RX_GOOD);
		exp_tx.push_back(PID_BYTE_ACK);
		wait_tx_packet("good OUT");
		check_tx("ACK to good OUT");
		check_bit(rx_data_ready, 1'b1, "rx_data_ready after good OUT");
		check_bit(rx_error, 1'b0, "rx_error after good OUT");
		ahb_drain(model_q.size());
	endtask

	task automatic run_out_bad(input int n);
		host_out(n, RX_BAD);
		model_q.delete();	// Corrupt payload flushed
		exp_tx.push_back(PID_BYTE_NAK);
		wait_tx_packet("bad OUT");
		check_tx("NAK to bad OUT");
		check_bit(rx_error, 1'b1, "rx_error after bad OUT");
		check_bit(rx_data_ready, 1'b0, "rx_data_ready after bad OUT");
		check_empty_pop();
	endtask

	task automatic run_in_data(input int n, input rx_pid_t reply);
		byte_t b;
		int    k;
		buffer_reserved     <= 1'b1;
		tx_packet_data_size <= occ_t'(n);
		for (k = 0; k < n; k++) begin
			b = byte_t'($urandom());
			ahb_wr_data <= b;
			ahb_wr_en   <= 1'b1;
			model_q.push_back(b);
			@(posedge clk);
		end
		ahb_wr_en       <= 1'b0;
		buffer_reserved <= 1'b0;	// Else IDLE reloads into AHB_STORE
		send_pid(RX_IN);
		exp_tx.push_back(PID_BYTE_DATA0);
		while (model_q.size() > 0)
			exp_tx.push_back(model_q.pop_front());	// Sender drains everything
		wait_tx_packet("IN with loaded buffer");
		check_tx("DATA0 packet");
		send_pid(reply);
		repeat (3) @(posedge clk);	// TX_ERROR_SET and the registered flag
		check_bit(tx_error, reply == RX_NAK, "tx_error after host reply");
		check_bit(rx_error, 1'b0, "rx_error after IN transfer");
	endtask

	task automatic run_out_busy(input int n);
		host_out(n, RX_GOOD);
		exp_tx.push_back(PID_BYTE_ACK);
		wait_tx_packet("first OUT");
		send_pid(RX_OUT);	// Data still unread
		exp_tx.push_back(PID_BYTE_NAK);
		wait_tx_packet("second OUT");
		check_tx("ACK then NAK with unread data");
		check_bit(rx_error, 1'b1, "rx_error after OUT on busy buffer");
		check_bit(rx_data_ready, 1'b1, "rx_data_ready with unread data");
		ahb_drain(model_q.size());
		repeat (2) @(posedge clk);
		run_in_empty();	// Back in idle once drained
	endtask

	initial begin
		int i;
		void'($urandom(32'h64ff_4ecd));
		n_mismatch          = 0;
		n_other             = 0;
		flag_mismatch       = 0;
		tx_base             = 0;
		n_rst               <= 1'b0;
		rx_packet           <= RX_IDLE;
		rx_byte             <= '0;
		rx_byte_valid       <= 1'b0;
		ahb_wr_data         <= '0;
		ahb_wr_en           <= 1'b0;
		ahb_rd_en           <= 1'b0;
		buffer_reserved     <= 1'b0;
		tx_packet_data_size <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		n_rst <= 1'b1;
		@(posedge clk);

		check_bit(rx_data_ready, 1'b0, "rx_data_ready after reset");
		check_bit(rx_transfer_active, 1'b0, "rx_transfer_active after reset");
		check_bit(rx_error, 1'b0, "rx_error after reset");
		check_bit(tx_transfer_active, 1'b0, "tx_transfer_active after reset");
		check_bit(tx_error, 1'b0, "tx_error after reset");
		check_bit(d_mode, 1'b0, "d_mode after reset");
		check_bit(tx_byte_valid, 1'b0, "tx_byte_valid after reset");
		check_empty_pop();

		for (i = 0; i < NUM_SCEN; i++) begin
			case (scen_tbl[i].kind)
				S_IN_EMPTY: run_in_empty();
				S_OUT_GOOD: run_out_good(int'(scen_tbl[i].n_bytes));
				S_OUT_BAD:  run_out_bad(int'(scen_tbl[i].n_bytes));
				S_IN_DATA:  run_in_data(int'(scen_tbl[i].n_bytes), scen_tbl[i].reply);
				S_OUT_BUSY: run_out_busy(int'(scen_tbl[i].n_bytes));
				default:    n_other++;
			endcase
			repeat (2) @(posedge clk);	// Controller back to idle
		end

		$display("Checks done: %0d mismatches, %0d other errors",
			n_mismatch + flag_mismatch, n_other);
		if (n_mismatch + flag_mismatch == 0 && n_other == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* compile.f */
rtl/usb_pid_pkg.sv
rtl/usb_buf_pkg.sv
rtl/buf_if.sv
rtl/protocol_controller.sv
rtl/data_buffer.sv
rtl/tx_packet_sender.sv
rtl/usb_endpoint_top.sv
dv/tb_usb_endpoint.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_usb_endpoint
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
